// File: prescaler_pkg.sv
// fixed point formats of the prescaler datapath, imported by each module that handles numbers
package prescaler_pkg;

  // a sample is a signed fraction with its value taken as the word divided by 2^16
  localparam int sample_width = 16;

  // scale factors and offsets share two integer bits
  localparam int scale_width      = 18;
  localparam int scale_int_bits   = 2;
  localparam int scale_frac_bits  = scale_width - scale_int_bits;
  localparam int offset_width     = 14;
  localparam int offset_int_bits  = 2;
  localparam int offset_frac_bits = offset_width - offset_int_bits;

  // full product width and where its binary point sits in value terms
  localparam int product_width     = sample_width + scale_width;
  localparam int product_frac_bits = sample_width + scale_frac_bits;

  // one extra bit so the offset addition cannot wrap
  localparam int sum_width = product_width + 1;

  // shift that lines an offset up with the product's binary point
  localparam int offset_shift = product_frac_bits - offset_frac_bits;

  // shift that brings a sum back to sample units
  localparam int out_shift = product_frac_bits - sample_width;

  typedef logic signed [sample_width-1:0]  sample_t;
  typedef logic signed [scale_width-1:0]   scale_t;
  typedef logic signed [offset_width-1:0]  offset_t;
  typedef logic signed [product_width-1:0] product_t;
  typedef logic signed [sum_width-1:0]     sum_t;

  // saturation limits of the output sample
  localparam sample_t sample_max = {1'b0, {(sample_width-1){1'b1}}};
  localparam sample_t sample_min = {1'b1, {(sample_width-1){1'b0}}};

endpackage

// File: stream_pkg.sv
// word layouts that travel between the controller, the source and the prescaler ports
package stream_pkg;

  import prescaler_pkg::*;

  // the sample stream itself is carried as port arrays sized by the
  // channels and parallel_samples parameters, with one valid bit per channel,
  // so none of its types depend on those parameters

  // settings word of one channel
  // the controller drives one of these per channel and marks the whole set
  // with a single config valid pulse
  // scale sits in the upper bits and offset in the lower bits of the word
  typedef struct packed {
    scale_t  scale;
    offset_t offset;
  } channel_cfg_t;

endpackage

// File: scale_mult.sv
// pipelined multiplier stage of the prescaler, scales each parallel sample by its channel's factor
`timescale 1ns/1ns

module scale_mult
  import prescaler_pkg::*;
#(
  parameter int channels         = 2,
  parameter int parallel_samples = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  sample_t             data [channels][parallel_samples],
  input  logic [channels-1:0] valid,
  input  scale_t              scale [channels],
  input  logic                scale_valid,
  output product_t            products [channels][parallel_samples],
  output logic [channels-1:0] prod_valid
);

  // captured scale factor per channel, zero until the first capture
  scale_t scale_q [channels];

  // first pipeline stage
  sample_t             data_q [channels][parallel_samples];
  logic [channels-1:0] valid_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      scale_q <= '{default: '0};
    end else if (scale_valid) begin
      scale_q <= scale;
    end
  end

  // samples are registered as they arrive, including invalid slots
  always_ff @(posedge clk) begin
    data_q <= data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid;
    end
  end

  // second stage has one multiplier per sample slot so a new beat can enter every cycle
  // both operands are sign extended to the full product width first
  always_ff @(posedge clk) begin
    for (int ch = 0; ch < channels; ch++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        products[ch][s] <= product_t'(data_q[ch][s]) * product_t'(scale_q[ch]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= '0;
    end else begin
      prod_valid <= valid_q;
    end
  end

endmodule

// File: offset_path.sv
// offset branch of the prescaler, holds each channel's offset aligned to the product binary point
`timescale 1ns/1ns

module offset_path
  import prescaler_pkg::*;
#(
  parameter int channels         = 2,
  parameter int parallel_samples = 4
) (
  input  logic    clk,
  input  logic    reset,
  input  offset_t offset [channels],
  input  logic    offset_valid,
  output sum_t    aligned_offset [channels]
);

  offset_t offset_q [channels];
  sum_t    aligned_d [channels];

  always_ff @(posedge clk) begin
    if (reset) begin
      offset_q <= '{default: '0};
    end else if (offset_valid) begin
      offset_q <= offset;
    end
  end

  // sign extend first, then move the 12 fraction bits up to the product's 32
  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      aligned_d[ch] = sum_t'(offset_q[ch]) <<< offset_shift;
    end
  end

  // the second register matches the two stage multiplier, so a capture
  // reaches the sum in the same cycle as the first samples it governs
  always_ff @(posedge clk) begin
    if (reset) begin
      aligned_offset <= '{default: '0};
    end else begin
      aligned_offset <= aligned_d;
    end
  end

  // an offset shifted this far must still fit inside the sum word
  if (offset_width + offset_shift >= sum_width) begin : g_bad_format
    $error("offset format does not fit the sum width");
  end

endmodule

// File: sum_saturate.sv
// output stage of the prescaler, adds offsets to products then floors and clamps to sample width
`timescale 1ns/1ns

module sum_saturate
  import prescaler_pkg::*;
#(
  parameter int channels         = 2,
  parameter int parallel_samples = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  product_t            products [channels][parallel_samples],
  input  logic [channels-1:0] prod_valid,
  input  sum_t                aligned_offset [channels],
  output sample_t             data [channels][parallel_samples],
  output logic [channels-1:0] valid
);

  sum_t sum [channels][parallel_samples];
  sum_t floored [channels][parallel_samples];

  // clamp a floored sum into the signed sample range
  function automatic sample_t saturate(input sum_t value);
    if (value > sum_t'(sample_max)) begin
      return sample_max;
    end else if (value < sum_t'(sample_min)) begin
      return sample_min;
    end
    return sample_t'(value);
  endfunction

  // the arithmetic shift drops the extra fraction bits and rounds toward minus infinity
  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        sum[ch][s]     = sum_t'(products[ch][s]) + aligned_offset[ch];
        floored[ch][s] = sum[ch][s] >>> out_shift;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int ch = 0; ch < channels; ch++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        data[ch][s] <= saturate(floored[ch][s]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else begin
      valid <= prod_valid;
    end
  end

endmodule

// File: dac_prescaler.sv
// top level of the DAC sample prescaler, scales and offsets each channel's stream in three cycles
`timescale 1ns/1ns

module dac_prescaler
  import prescaler_pkg::*;
  import stream_pkg::*;
#(
  parameter int channels         = 2,
  parameter int parallel_samples = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  sample_t             in_data [channels][parallel_samples],
  input  logic [channels-1:0] in_valid,
  input  channel_cfg_t        cfg [channels],
  input  logic                cfg_valid,
  output sample_t             out_data [channels][parallel_samples],
  output logic [channels-1:0] out_valid
);

  scale_t              cfg_scale [channels];
  offset_t             cfg_offset [channels];
  product_t            products [channels][parallel_samples];
  logic [channels-1:0] prod_valid;
  sum_t                aligned_offset [channels];

  // each settings word feeds the multiplier with its scale and the offset branch with its offset
  for (genvar ch = 0; ch < channels; ch++) begin : g_cfg_split
    assign cfg_scale[ch]  = cfg[ch].scale;
    assign cfg_offset[ch] = cfg[ch].offset;
  end

  scale_mult #(
    .channels        (channels),
    .parallel_samples(parallel_samples)
  ) u_scale_mult (
    .clk        (clk),
    .reset      (reset),
    .data       (in_data),
    .valid      (in_valid),
    .scale      (cfg_scale),
    .scale_valid(cfg_valid),
    .products   (products),
    .prod_valid (prod_valid)
  );

  offset_path #(
    .channels        (channels),
    .parallel_samples(parallel_samples)
  ) u_offset_path (
    .clk           (clk),
    .reset         (reset),
    .offset        (cfg_offset),
    .offset_valid  (cfg_valid),
    .aligned_offset(aligned_offset)
  );

  sum_saturate #(
    .channels        (channels),
    .parallel_samples(parallel_samples)
  ) u_sum_saturate (
    .clk           (clk),
    .reset         (reset),
    .products      (products),
    .prod_valid    (prod_valid),
    .aligned_offset(aligned_offset),
    .data          (out_data),
    .valid         (out_valid)
  );

endmodule

// File: tb_clock_gen.sv
// clock source for the prescaler testbench, free running from time zero with a 4 ns period
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int half_period = 2
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #half_period clk = ~clk;
    end
  end

endmodule

// File: dac_prescaler_asserts.sv
// concurrent checks on the prescaler's valid timing, bound into every dac_prescaler instance
`timescale 1ns/1ns

module dac_prescaler_asserts #(
  parameter int channels = 2
) (
  input logic                clk,
  input logic                reset,
  input logic [channels-1:0] in_valid,
  input logic [channels-1:0] out_valid
);

  // reset level at the last three edges, oldest in the top bit
  logic [2:0] reset_hist = 3'b000;

  // edges seen so far, saturating, so the history is only trusted once it exists
  logic [1:0] edge_count = 2'd0;

  always @(posedge clk) begin
    reset_hist <= {reset_hist[1:0], reset};
    if (edge_count != 2'd3) begin
      edge_count <= edge_count + 2'd1;
    end
  end

  // each channel's valid pattern leaves the pipeline exactly three cycles after it enters
  valid_delay: assert property (
    @(posedge clk) (edge_count == 2'd3 && reset_hist == 3'b000)
      |-> (out_valid == $past(in_valid, 3))
  ) else $error("out_valid does not follow in_valid by three cycles");

  // nothing valid may leave the pipeline in the three cycles after reset
  valid_cleared: assert property (
    @(posedge clk) (edge_count != 2'd0 && reset_hist != 3'b000) |-> (out_valid == '0)
  ) else $error("out_valid set within three cycles of reset");

endmodule

bind dac_prescaler dac_prescaler_asserts #(
  .channels(channels)
) u_asserts (
  .clk      (clk),
  .reset    (reset),
  .in_valid (in_valid),
  .out_valid(out_valid)
);

// File: dac_prescaler_tb.sv
// testbench for the DAC prescaler, drives random streams and settings and checks every output
`timescale 1ns/1ns

module dac_prescaler_tb
  import prescaler_pkg::*;
  import stream_pkg::*;
();

  localparam int channels         = 2;
  localparam int parallel_samples = 4;
  localparam int timeout_cycles   = 6000;

  // extreme settings for the saturation test
  localparam scale_t  scale_hi  = {1'b0, {(scale_width-1){1'b1}}};
  localparam scale_t  scale_lo  = {1'b1, {(scale_width-1){1'b0}}};
  localparam offset_t offset_hi = {1'b0, {(offset_width-1){1'b1}}};
  localparam offset_t offset_lo = {1'b1, {(offset_width-1){1'b0}}};

  logic                clk;
  logic                reset;
  sample_t             in_data [channels][parallel_samples];
  logic [channels-1:0] in_valid;
  channel_cfg_t        cfg [channels];
  logic                cfg_valid;
  sample_t             out_data [channels][parallel_samples];
  logic [channels-1:0] out_valid;

  // settings the DUT holds after its last capture, as the reference sees them
  scale_t  model_scale [channels];
  offset_t model_offset [channels];

  // expected outputs of each channel in arrival order
  sample_t expected_q [channels][$];
  int      cycle_count = 0;

  tb_clock_gen #(.half_period(2)) u_clock_gen (.clk(clk));

  dac_prescaler #(
    .channels        (channels),
    .parallel_samples(parallel_samples)
  ) uut (
    .clk      (clk),
    .reset    (reset),
    .in_data  (in_data),
    .in_valid (in_valid),
    .cfg      (cfg),
    .cfg_valid(cfg_valid),
    .out_data (out_data),
    .out_valid(out_valid)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped after the first error");
  endtask

  // sample times scale plus offset times 2^20, floored by 2^16, then clamped
  function automatic sample_t expected_sample(input sample_t sample, input scale_t scale,
                                              input offset_t offset);
    longint sum;
    longint quotient;
    sum = longint'(sample) * longint'(scale) + longint'(offset) * 1048576;
    quotient = sum / 65536;
    // division truncates toward zero, so negative remainders need one more step down
    if ((sum % 65536) != 0 && sum < 0) begin
      quotient = quotient - 1;
    end
    if (quotient > 32767) begin
      return sample_t'(32767);
    end else if (quotient < -32768) begin
      return sample_t'(-32768);
    end
    return sample_t'(quotient);
  endfunction

  function automatic logic [channels-1:0] random_mask();
    logic [channels-1:0] mask;
    for (int ch = 0; ch < channels; ch++) begin
      mask[ch] = ($urandom_range(0, 3) != 0);
    end
    return mask;
  endfunction

  function automatic bit queues_empty();
    for (int ch = 0; ch < channels; ch++) begin
      if (expected_q[ch].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic drive_beat(input logic [channels-1:0] mask, input bit fixed,
                            input sample_t fixed_value);
    @(posedge clk);
    #1;
    for (int ch = 0; ch < channels; ch++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        in_data[ch][s] = fixed ? fixed_value : sample_t'($urandom);
        if (mask[ch]) begin
          expected_q[ch].push_back(
            expected_sample(in_data[ch][s], model_scale[ch], model_offset[ch]));
        end
      end
    end
    in_valid = mask;
  endtask

  task automatic idle_cycles(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      in_valid = '0;
    end
  endtask

  // one cycle of cfg_valid, the reference takes the new settings at the same time
  task automatic pulse_cfg();
    @(posedge clk);
    #1;
    in_valid  = '0;
    cfg_valid = 1'b1;
    for (int ch = 0; ch < channels; ch++) begin
      model_scale[ch]  = cfg[ch].scale;
      model_offset[ch] = cfg[ch].offset;
    end
    @(posedge clk);
    #1;
    cfg_valid = 1'b0;
  endtask

  // mild settings keep most results inside the sample range
  task automatic load_random_settings(input bit mild);
    for (int ch = 0; ch < channels; ch++) begin
      if (mild) begin
        cfg[ch].scale  = scale_t'($urandom_range(0, 65535) - 32768);
        cfg[ch].offset = offset_t'($urandom_range(0, 2047) - 1024);
      end else begin
        cfg[ch].scale  = scale_t'($urandom);
        cfg[ch].offset = offset_t'($urandom);
      end
    end
    pulse_cfg();
  endtask

  task automatic load_fixed_settings(input scale_t scale, input offset_t offset);
    for (int ch = 0; ch < channels; ch++) begin
      cfg[ch].scale  = scale;
      cfg[ch].offset = offset;
    end
    pulse_cfg();
  endtask

  task automatic wait_drained();
    while (!queues_empty()) begin
      @(posedge clk);
    end
    #1;
  endtask

  // beats still in the pipeline are lost in reset, so their expected values go too
  task automatic apply_reset(input int cycles);
    @(posedge clk);
    #1;
    reset     = 1'b1;
    in_valid  = '0;
    cfg_valid = 1'b0;
    repeat (cycles) begin
      @(posedge clk);
      #1;
      assert (out_valid == '0) else fail_run("out_valid still set while reset is held");
    end
    reset = 1'b0;
    for (int ch = 0; ch < channels; ch++) begin
      model_scale[ch]  = '0;
      model_offset[ch] = '0;
      expected_q[ch].delete();
    end
  endtask

  // outputs are stable at the falling edge, halfway between two updates
  always @(negedge clk) begin
    sample_t want;
    for (int ch = 0; ch < channels; ch++) begin
      if (out_valid[ch] === 1'b1) begin
        assert (expected_q[ch].size() >= parallel_samples)
          else fail_run($sformatf("output valid on channel %0d with no sample pending", ch));
        for (int s = 0; s < parallel_samples; s++) begin
          want = expected_q[ch].pop_front();
          assert (out_data[ch][s] === want)
            else fail_run($sformatf("mismatch at %0t: channel %0d slot %0d got %0d expected %0d",
                                    $time, ch, s, out_data[ch][s], want));
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      fail_run($sformatf("timeout after %0d cycles with outputs still expected", cycle_count));
    end
  end

  initial begin
    void'($urandom(73510));
    reset     = 1'b1;
    in_valid  = '0;
    cfg_valid = 1'b0;
    in_data   = '{default: '0};
    cfg       = '{default: '0};
    model_scale  = '{default: '0};
    model_offset = '{default: '0};
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    // continuous valid on both channels, full range settings and then mild ones
    load_random_settings(1'b0);
    repeat (400) drive_beat('1, 1'b0, '0);
    idle_cycles(5);
    load_random_settings(1'b1);
    repeat (400) drive_beat('1, 1'b0, '0);
    idle_cycles(5);

    // independent gaps in each channel's valid
    repeat (1200) drive_beat(random_mask(), 1'b0, '0);
    idle_cycles(5);

    // bursts with new settings between them
    for (int b = 0; b < 6; b++) begin
      load_random_settings((b % 2) == 1);
      idle_cycles(5);
      repeat (150) drive_beat('1, 1'b0, '0);
      idle_cycles(5);
    end

    // extreme settings push the sum past the sample range in both directions
    load_fixed_settings(scale_hi, offset_hi);
    repeat (20) drive_beat('1, 1'b1, sample_max);
    repeat (20) drive_beat('1, 1'b0, '0);
    idle_cycles(5);
    load_fixed_settings(scale_lo, offset_lo);
    repeat (20) drive_beat('1, 1'b1, sample_min);
    repeat (20) drive_beat('1, 1'b0, '0);
    idle_cycles(5);

    // reset in the middle of the run clears the settings, so outputs are zero until a capture
    // samples are still in flight when reset arrives
    repeat (50) drive_beat('1, 1'b0, '0);
    apply_reset(10);
    repeat (30) drive_beat('1, 1'b0, '0);
    idle_cycles(5);
    load_random_settings(1'b1);
    repeat (150) drive_beat(random_mask(), 1'b0, '0);
    idle_cycles(5);
    wait_drained();

    if (queues_empty()) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_run("expected outputs still pending at the end of the run");
    end
  end

endmodule

// File: src.f
prescaler_pkg.sv
stream_pkg.sv
scale_mult.sv
offset_path.sv
sum_saturate.sv
dac_prescaler.sv
tb_clock_gen.sv
dac_prescaler_asserts.sv
dac_prescaler_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := dac_prescaler_tb
FILELIST   := src.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
